/* sim.f */
hw/noc_alloc_pkg.sv
hw/alloc_if.sv
hw/rr_arbiter.sv
hw/input_stage.sv
hw/output_stage.sv
hw/vc_grant_stage.sv
hw/nonspec_allocator.sv
sim/nonspec_allocator_chk.sv
sim/tb_nonspec_allocator.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_nonspec_allocator \
    -Mdir obj_dir -f sim.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_nonspec_allocator +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim/tb_nonspec_allocator.sv */
`default_nettype none

module tb_nonspec_allocator;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;
    localparam int num_rows     = 15;
    localparam int num_slots    = 3;
    localparam int idle_cycles  = 32;

    // one requesting input VC of a table row
    typedef struct packed {
        logic                    en;
        logic [2:0]              port;
        logic [1:0]              vc;
        logic                    asg;
        logic                    not_full;
        noc_alloc_pkg::vc_mask_t offer;
        // absolute output port
        logic [2:0]              dest;
        // expected to win the switch this cycle
        logic                    win;
    } req_t;

    logic                      clk = 1'b0;
    logic                      arst_n;
    noc_alloc_pkg::ivc_ovc_t   ovc_request;
    noc_alloc_pkg::ivc_dest_t  dest_port;
    noc_alloc_pkg::ivc_vec_t   ovc_is_assigned;
    noc_alloc_pkg::ivc_vec_t   ivc_request;
    noc_alloc_pkg::ivc_vec_t   assigned_ovc_not_full;
    noc_alloc_pkg::ivc_vec_t   ivc_sw_grant;
    noc_alloc_pkg::ivc_vec_t   ivc_ovc_grant;
    noc_alloc_pkg::ivc_ovc_t   granted_ovc;
    noc_alloc_pkg::port_dest_t granted_dest;
    noc_alloc_pkg::port_vec_t  port_granted;
    noc_alloc_pkg::port_vec_t  out_port_busy;
    noc_alloc_pkg::ivc_vec_t   ovc_allocated;

    // expected outputs of the current step
    noc_alloc_pkg::ivc_vec_t   exp_sw_grant;
    noc_alloc_pkg::ivc_vec_t   exp_ovc_grant;
    noc_alloc_pkg::ivc_ovc_t   exp_granted_ovc;
    noc_alloc_pkg::port_dest_t exp_granted_dest;
    noc_alloc_pkg::port_vec_t  exp_port_granted;
    noc_alloc_pkg::port_vec_t  exp_busy;
    noc_alloc_pkg::ivc_vec_t   exp_allocated;

    req_t        table_rows [num_rows][num_slots];
    logic [15:0] lfsr_state;
    int          step;
    int          check_count;
    int          error_count;
    int          assert_fails;

    nonspec_allocator dut (.*);

    bind nonspec_allocator nonspec_allocator_chk u_chk (
        .clk           (clk),
        .arst_n        (arst_n),
        .ivc_sw_grant  (ivc_sw_grant),
        .ivc_ovc_grant (ivc_ovc_grant),
        .granted_ovc   (granted_ovc),
        .granted_dest  (granted_dest),
        .port_granted  (port_granted),
        .out_port_busy (out_port_busy),
        .ovc_allocated (ovc_allocated)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic req_t make_req(input int port, input int vc, input bit asg,
                                      input bit nf, input noc_alloc_pkg::vc_mask_t offer,
                                      input int dest, input bit win);
        req_t q;
        q.en       = 1'b1;
        q.port     = 3'(port);
        q.vc       = 2'(vc);
        q.asg      = asg;
        q.not_full = nf;
        q.offer    = offer;
        q.dest     = 3'(dest);
        q.win      = win;
        return q;
    endfunction

    // winners worked out by hand from the round-robin rule, pointers at 0 after reset
    task automatic fill_table();
        for (int r = 0; r < num_rows; r++) begin
            for (int s = 0; s < num_slots; s++) begin
                table_rows[r][s] = '0;
            end
        end
        // lone new VC, then assigned VC with its OVC free and full
        table_rows[1][0] = make_req(1, 2, 0, 0, 4'b1000, 3, 1);
        table_rows[2][0] = make_req(0, 1, 1, 1, 4'b0010, 2, 1);
        table_rows[3][0] = make_req(0, 1, 1, 0, 4'b0010, 2, 0);
        // ports 0 and 2 fight for output 4, port 0 first
        for (int k = 0; k < 4; k++) begin
            table_rows[4+k][0] = make_req(0, 2, 1, 1, 4'b0000, 4, (k % 2) == 0);
            table_rows[4+k][1] = make_req(2, 0, 0, 0, 4'b0010, 4, (k % 2) == 1);
        end
        // two VCs of port 3, pointer stays put while port 4 takes output 0
        table_rows[8][0]  = make_req(3, 1, 1, 1, 4'b0000, 0, 1);
        table_rows[8][1]  = make_req(3, 2, 0, 0, 4'b0100, 1, 0);
        table_rows[9][0]  = make_req(3, 1, 1, 1, 4'b0000, 0, 0);
        table_rows[9][1]  = make_req(3, 2, 0, 0, 4'b0100, 1, 1);
        table_rows[10][0] = make_req(3, 1, 1, 1, 4'b0000, 0, 0);
        table_rows[10][1] = make_req(3, 2, 0, 0, 4'b0100, 1, 0);
        table_rows[10][2] = make_req(4, 0, 1, 1, 4'b0000, 0, 1);
        table_rows[11][0] = make_req(3, 1, 1, 1, 4'b0000, 0, 1);
        table_rows[11][1] = make_req(3, 2, 0, 0, 4'b0100, 1, 0);
        table_rows[12][0] = make_req(3, 1, 1, 1, 4'b0000, 0, 0);
        table_rows[12][1] = make_req(3, 2, 0, 0, 4'b0100, 1, 1);
        // two new VCs at different outputs win together
        table_rows[13][0] = make_req(1, 0, 0, 0, 4'b0001, 2, 1);
        table_rows[13][1] = make_req(2, 3, 0, 0, 4'b1000, 0, 1);
    endtask

    task automatic clear_inputs();
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        ovc_request           = '0;
        dest_port             = '0;
    endtask

    task automatic clear_expected();
        exp_sw_grant     = '0;
        exp_ovc_grant    = '0;
        exp_granted_ovc  = '0;
        exp_granted_dest = '0;
        exp_port_granted = '0;
        exp_busy         = '0;
        exp_allocated    = '0;
    endtask

    task automatic drive_row(input int r);
        req_t        q;
        int unsigned i;
        int unsigned base;
        int unsigned d;
        clear_inputs();
        clear_expected();
        for (int s = 0; s < num_slots; s++) begin
            q = table_rows[r][s];
            if (q.en) begin
                base = q.port * noc_alloc_pkg::num_vcs;
                i    = base + q.vc;
                d    = noc_alloc_pkg::port_to_dest(q.port, q.dest);
                ivc_request[i]           = 1'b1;
                ovc_is_assigned[i]       = q.asg;
                assigned_ovc_not_full[i] = q.not_full;
                ovc_request[i]           = q.offer;
                dest_port[i][d]          = 1'b1;
                if (q.win) begin
                    exp_sw_grant[i]        = 1'b1;
                    exp_port_granted[q.port] = 1'b1;
                    exp_busy[q.dest]       = 1'b1;
                    exp_granted_dest[q.port][d] = 1'b1;
                    // new VC also takes the single offered OVC
                    if (!q.asg) begin
                        exp_ovc_grant[i] = 1'b1;
                        for (int k = 0; k < noc_alloc_pkg::num_vcs; k++) begin
                            exp_granted_ovc[base + k] = q.offer;
                            if (q.offer[k]) begin
                                exp_allocated[q.dest * noc_alloc_pkg::num_vcs + k] = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    endtask

    // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [79:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[b]    = lfsr_state[0];
        end
    endtask

    // random side inputs, but no VC requests
    task automatic drive_idle();
        logic [79:0] bits;
        ivc_request = '0;
        take_bits(80, bits);
        ovc_request = bits;
        take_bits(80, bits);
        dest_port = bits;
        take_bits(20, bits);
        ovc_is_assigned = bits[19:0];
        take_bits(20, bits);
        assigned_ovc_not_full = bits[19:0];
        clear_expected();
    endtask

    task automatic check_ivc(input string name, input noc_alloc_pkg::ivc_vec_t exp_v,
                             input noc_alloc_pkg::ivc_vec_t act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("ERR %s expected %h actual %h at step %0d", name, exp_v, act_v, step);
        end
    endtask

    task automatic check_ovc(input string name, input noc_alloc_pkg::ivc_ovc_t exp_v,
                             input noc_alloc_pkg::ivc_ovc_t act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("ERR %s expected %h actual %h at step %0d", name, exp_v, act_v, step);
        end
    endtask

    task automatic check_dest(input string name, input noc_alloc_pkg::port_dest_t exp_v,
                              input noc_alloc_pkg::port_dest_t act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("ERR %s expected %h actual %h at step %0d", name, exp_v, act_v, step);
        end
    endtask

    task automatic check_port(input string name, input noc_alloc_pkg::port_vec_t exp_v,
                              input noc_alloc_pkg::port_vec_t act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            $display("ERR %s expected %h actual %h at step %0d", name, exp_v, act_v, step);
        end
    endtask

    task automatic compare_outputs();
        check_ivc("ivc_sw_grant", exp_sw_grant, ivc_sw_grant);
        check_ivc("ivc_ovc_grant", exp_ovc_grant, ivc_ovc_grant);
        check_ovc("granted_ovc", exp_granted_ovc, granted_ovc);
        check_dest("granted_dest", exp_granted_dest, granted_dest);
        check_port("port_granted", exp_port_granted, port_granted);
        check_port("out_port_busy", exp_busy, out_port_busy);
        check_ivc("ovc_allocated", exp_allocated, ovc_allocated);
    endtask

    // run length plus margin
    initial begin
        #((num_rows + reset_cycles + idle_cycles + 50) * clk_period);
        $display("timeout: the allocator run did not reach its end");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        lfsr_state  = 16'd75;
        step        = -1;
        check_count = 0;
        error_count = 0;
        clear_inputs();
        clear_expected();
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // drive 1 ns after the edge, sample 1 ns before the next one
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            #1;
            step = r;
            drive_row(r);
            #(clk_period - 2);
            compare_outputs();
        end
        for (int c = 0; c < idle_cycles; c++) begin
            @(posedge clk);
            #1;
            step = num_rows + c;
            drive_idle();
            #(clk_period - 2);
            compare_outputs();
        end
        assert_fails = int'(dut.u_chk.dest_fails + dut.u_chk.busy_fails +
                            dut.u_chk.reset_fails);
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/nonspec_allocator_chk.sv */
`default_nettype none

module nonspec_allocator_chk (
    input wire logic                      clk,
    input wire logic                      arst_n,
    input wire noc_alloc_pkg::ivc_vec_t   ivc_sw_grant,
    input wire noc_alloc_pkg::ivc_vec_t   ivc_ovc_grant,
    input wire noc_alloc_pkg::ivc_ovc_t   granted_ovc,
    input wire noc_alloc_pkg::port_dest_t granted_dest,
    input wire noc_alloc_pkg::port_vec_t  port_granted,
    input wire noc_alloc_pkg::port_vec_t  out_port_busy,
    input wire noc_alloc_pkg::ivc_vec_t   ovc_allocated
);
    timeunit 1ns;
    timeprecision 1ps;

    // failure counts, read back from the testbench top
    int unsigned dest_fails  = 0;
    int unsigned busy_fails  = 0;
    int unsigned reset_fails = 0;

    // at most one destination per input port
    function automatic logic dest_onehot0(input noc_alloc_pkg::port_dest_t d);
        logic ok;
        ok = 1'b1;
        for (int p = 0; p < noc_alloc_pkg::num_ports; p++) begin
            if (!$onehot0(d[p])) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    a_dest_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        dest_onehot0(granted_dest))
    else begin
        $error("granted_dest holds more than one destination for a port");
        dest_fails++;
    end

    // a busy output always has a switch winner behind it
    a_busy_needs_grant: assert property (@(posedge clk) disable iff (!arst_n)
        (|out_port_busy) |-> (|ivc_sw_grant))
    else begin
        $error("out_port_busy set with no switch grant");
        busy_fails++;
    end

    // nothing granted while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (ivc_sw_grant == '0 && ivc_ovc_grant == '0 && granted_ovc == '0 &&
                     granted_dest == '0 && port_granted == '0 && ovc_allocated == '0))
    else begin
        $error("grant output active during reset");
        reset_fails++;
    end

endmodule

`default_nettype wire

/* hw/nonspec_allocator.sv */
`default_nettype none

module nonspec_allocator (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    // requests from the input ports
    input  wire noc_alloc_pkg::ivc_ovc_t   ovc_request,
    input  wire noc_alloc_pkg::ivc_dest_t  dest_port,
    input  wire noc_alloc_pkg::ivc_vec_t   ovc_is_assigned,
    input  wire noc_alloc_pkg::ivc_vec_t   ivc_request,
    input  wire noc_alloc_pkg::ivc_vec_t   assigned_ovc_not_full,
    // grants back to the input ports
    output noc_alloc_pkg::ivc_vec_t        ivc_sw_grant,
    output noc_alloc_pkg::ivc_vec_t        ivc_ovc_grant,
    output noc_alloc_pkg::ivc_ovc_t        granted_ovc,
    output noc_alloc_pkg::port_dest_t      granted_dest,
    output noc_alloc_pkg::port_vec_t       port_granted,
    // status toward the output ports
    output noc_alloc_pkg::port_vec_t       out_port_busy,
    output noc_alloc_pkg::ivc_vec_t        ovc_allocated
);

    // shared between the three stages
    alloc_if alloc_bus ();

    // masking, OVC candidates, first-level arbitration
    input_stage u_input_stage (
        .clk                   (clk),
        .arst_n                (arst_n),
        .ivc_request           (ivc_request),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .ovc_request           (ovc_request),
        .dest_port             (dest_port),
        .alloc_bus             (alloc_bus.input_side)
    );

    // second-level arbitration per output port
    output_stage u_output_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .alloc_bus     (alloc_bus.output_side),
        .out_port_busy (out_port_busy)
    );

    // switch and OVC grants
    vc_grant_stage u_vc_grant_stage (
        .alloc_bus     (alloc_bus.grant_side),
        .ivc_sw_grant  (ivc_sw_grant),
        .ivc_ovc_grant (ivc_ovc_grant),
        .granted_ovc   (granted_ovc),
        .ovc_allocated (ovc_allocated)
    );

    // per-port results straight off the bus
    assign granted_dest = alloc_bus.granted_dest_int;
    assign port_granted = alloc_bus.port_won;

endmodule

`default_nettype wire

/* hw/vc_grant_stage.sv */
`default_nettype none

module vc_grant_stage (
    alloc_if.grant_side                    alloc_bus,
    output noc_alloc_pkg::ivc_vec_t        ivc_sw_grant,
    output noc_alloc_pkg::ivc_vec_t        ivc_ovc_grant,
    output noc_alloc_pkg::ivc_ovc_t        granted_ovc,
    output noc_alloc_pkg::ivc_vec_t        ovc_allocated
);

    // per-VC grants of each input port
    always_comb begin
        ivc_sw_grant  = '0;
        ivc_ovc_grant = '0;
        granted_ovc   = '0;
        for (int unsigned p = 0; p < noc_alloc_pkg::num_ports; p++) begin
            for (int unsigned v = 0; v < noc_alloc_pkg::num_vcs; v++) begin
                // switch grant only for the first-level winner of a winning port
                ivc_sw_grant[noc_alloc_pkg::ivc_index(p, v)] =
                    alloc_bus.port_won[p] & alloc_bus.first_grant[p][v];
                // new OVC only if the winner carried a candidate
                ivc_ovc_grant[noc_alloc_pkg::ivc_index(p, v)] =
                    alloc_bus.port_won[p] & (|alloc_bus.cand_ovc[p]) &
                    alloc_bus.first_grant[p][v];
                // same OVC number repeated over every VC slot of the port
                if (alloc_bus.port_won[p]) begin
                    granted_ovc[noc_alloc_pkg::ivc_index(p, v)] = alloc_bus.cand_ovc[p];
                end
            end
        end
    end

    // mark the taken OVC at the output port the candidate is going to
    // granted_dest_int is already zero for ports that lost
    always_comb begin
        ovc_allocated = '0;
        for (int unsigned o = 0; o < noc_alloc_pkg::num_ports; o++) begin
            for (int unsigned j = 0; j < noc_alloc_pkg::num_ports; j++) begin
                if (j != o) begin
                    for (int unsigned v = 0; v < noc_alloc_pkg::num_vcs; v++) begin
                        ovc_allocated[noc_alloc_pkg::ivc_index(o, v)] =
                            ovc_allocated[noc_alloc_pkg::ivc_index(o, v)] |
                            (alloc_bus.granted_dest_int[j][noc_alloc_pkg::port_to_dest(j, o)] &
                             alloc_bus.cand_ovc[j][v]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/output_stage.sv */
`default_nettype none

module output_stage (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    alloc_if.output_side                   alloc_bus,
    output noc_alloc_pkg::port_vec_t       out_port_busy
);

    // per output port, one request bit per other input port
    noc_alloc_pkg::port_dest_t out_req;
    // per output port, one-hot winning input port
    noc_alloc_pkg::port_dest_t out_grant;

    // transpose winner destinations into output-port requests
    // an input port never targets itself, so that entry is skipped
    always_comb begin
        out_req = '0;
        for (int unsigned o = 0; o < noc_alloc_pkg::num_ports; o++) begin
            for (int unsigned j = 0; j < noc_alloc_pkg::num_ports; j++) begin
                if (j != o) begin
                    out_req[o][noc_alloc_pkg::port_to_dest(o, j)] =
                        alloc_bus.winner_dest[j][noc_alloc_pkg::port_to_dest(j, o)];
                end
            end
        end
    end

    for (genvar o = 0; o < noc_alloc_pkg::num_ports; o++) begin : g_out
        // second level, one input port per output port
        rr_arbiter #(
            .width     (noc_alloc_pkg::num_dests)
        ) u_out_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (out_req[o]),
            .update_en (1'b1),
            .grant     (out_grant[o]),
            .any_grant (out_port_busy[o])
        );
    end

    // transpose grants back into the input-port numbering
    always_comb begin
        alloc_bus.granted_dest_int = '0;
        for (int unsigned j = 0; j < noc_alloc_pkg::num_ports; j++) begin
            for (int unsigned o = 0; o < noc_alloc_pkg::num_ports; o++) begin
                if (o != j) begin
                    alloc_bus.granted_dest_int[j][noc_alloc_pkg::port_to_dest(j, o)] =
                        out_grant[o][noc_alloc_pkg::port_to_dest(o, j)];
                end
            end
        end
    end

    // input port won when some output took it
    for (genvar j = 0; j < noc_alloc_pkg::num_ports; j++) begin : g_won
        assign alloc_bus.port_won[j] = |alloc_bus.granted_dest_int[j];
    end

endmodule

`default_nettype wire

/* hw/input_stage.sv */
`default_nettype none

module input_stage (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire noc_alloc_pkg::ivc_vec_t   ivc_request,
    input  wire noc_alloc_pkg::ivc_vec_t   ovc_is_assigned,
    input  wire noc_alloc_pkg::ivc_vec_t   assigned_ovc_not_full,
    input  wire noc_alloc_pkg::ivc_ovc_t   ovc_request,
    input  wire noc_alloc_pkg::ivc_dest_t  dest_port,
    alloc_if.input_side                    alloc_bus
);

    // offered OVCs, kept only for unassigned VCs that request
    noc_alloc_pkg::ivc_ovc_t ovc_offer;
    // one OVC candidate per input VC
    noc_alloc_pkg::ivc_ovc_t ovc_cand;
    // request entering the input-port arbiters
    noc_alloc_pkg::ivc_vec_t masked_request;
    // input-port arbiter grants
    noc_alloc_pkg::vc_mask_t [noc_alloc_pkg::num_ports-1:0] port_grant;

    for (genvar i = 0; i < noc_alloc_pkg::num_ivcs; i++) begin : g_ivc
        // new packet asks for any of the offered OVCs
        assign ovc_offer[i] = (ivc_request[i] && !ovc_is_assigned[i]) ?
                              ovc_request[i] : '0;

        // assigned VC stalls while its OVC is full
        assign masked_request[i] = ovc_is_assigned[i] ?
                                   (ivc_request[i] & assigned_ovc_not_full[i]) :
                                   (|ovc_offer[i]);

        // pick one free OVC for this input VC
        rr_arbiter #(
            .width     (noc_alloc_pkg::num_vcs)
        ) u_ovc_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (ovc_offer[i]),
            .update_en (1'b1),
            .grant     (ovc_cand[i]),
            .any_grant ()
        );
    end

    for (genvar p = 0; p < noc_alloc_pkg::num_ports; p++) begin : g_port
        // one input VC per port
        // pointer only moves once the port actually wins an output
        rr_arbiter #(
            .width     (noc_alloc_pkg::num_vcs)
        ) u_in_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (masked_request[p*noc_alloc_pkg::num_vcs +: noc_alloc_pkg::num_vcs]),
            .update_en (alloc_bus.port_won[p]),
            .grant     (port_grant[p]),
            .any_grant ()
        );
    end

    assign alloc_bus.first_grant = port_grant;

    // one-hot mux of the winner's destination and OVC candidate
    always_comb begin
        alloc_bus.winner_dest = '0;
        alloc_bus.cand_ovc    = '0;
        for (int unsigned p = 0; p < noc_alloc_pkg::num_ports; p++) begin
            for (int unsigned v = 0; v < noc_alloc_pkg::num_vcs; v++) begin
                if (port_grant[p][v]) begin
                    alloc_bus.winner_dest[p] = alloc_bus.winner_dest[p] |
                        dest_port[noc_alloc_pkg::ivc_index(p, v)];
                    alloc_bus.cand_ovc[p] = alloc_bus.cand_ovc[p] |
                        ovc_cand[noc_alloc_pkg::ivc_index(p, v)];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rr_arbiter.sv */
`default_nettype none

module rr_arbiter #(
    parameter int unsigned width = 4
) (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic [width-1:0] request,
    input  wire logic             update_en,
    output logic      [width-1:0] grant,
    output logic                  any_grant
);

    // one-hot pointer, marks the index with top priority
    logic [width-1:0]   ptr;
    // request vector seen twice, so the search can wrap
    logic [2*width-1:0] double_req;
    logic [2*width-1:0] double_gnt;

    assign double_req = {request, request};

    // subtracting the pointer clears every bit below it up to the first
    // request at or after the pointer, and the and-not keeps only that bit
    assign double_gnt = double_req & ~(double_req - {{width{1'b0}}, ptr});

    // the winner sits in the low copy or, after wrapping, in the high copy
    assign grant = double_gnt[width-1:0] | double_gnt[2*width-1:width];

    assign any_grant = |request;

    // pointer moves to one past the winner
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // favor index 0 out of reset
            ptr <= width'(1);
        end else if (update_en && any_grant) begin
            // rotate left by one, top bit wraps to bit 0
            ptr <= (grant << 1) | (grant >> (width - 1));
        end
    end

endmodule

`default_nettype wire

/* hw/alloc_if.sv */
`default_nettype none

interface alloc_if;

    // winning input VC of each input port, one-hot per port
    noc_alloc_pkg::vc_mask_t [noc_alloc_pkg::num_ports-1:0] first_grant;
    // destination requested by each port winner
    noc_alloc_pkg::port_dest_t                              winner_dest;
    // OVC candidate of each port winner, zero for an assigned VC
    noc_alloc_pkg::vc_mask_t [noc_alloc_pkg::num_ports-1:0] cand_ovc;
    // destination actually granted to each input port
    noc_alloc_pkg::port_dest_t                              granted_dest_int;
    // input port got its output this cycle
    noc_alloc_pkg::port_vec_t                               port_won;

    // request masking and first-level arbitration
    modport input_side (
        output first_grant,
        output winner_dest,
        output cand_ovc,
        input  port_won
    );

    // output port arbitration
    modport output_side (
        input  winner_dest,
        output granted_dest_int,
        output port_won
    );

    // grant assembly
    modport grant_side (
        input first_grant,
        input cand_ovc,
        input granted_dest_int,
        input port_won
    );

endinterface

`default_nettype wire

/* hw/noc_alloc_pkg.sv */
`default_nettype none

package noc_alloc_pkg;

    // router geometry
    localparam int unsigned num_ports = 5;
    localparam int unsigned num_vcs   = 4;
    // a packet never turns back to its own port
    localparam int unsigned num_dests = num_ports - 1;
    localparam int unsigned num_ivcs  = num_ports * num_vcs;

    // one bit per VC of a single port
    typedef logic [num_vcs-1:0] vc_mask_t;

    // one-hot over the other ports, port-local numbering
    typedef logic [num_dests-1:0] dest_t;

    // one bit per router port
    typedef logic [num_ports-1:0] port_vec_t;

    // one bit per input VC, port-major
    typedef logic [num_ivcs-1:0] ivc_vec_t;

    // vc mask per input VC, port-major
    typedef vc_mask_t [num_ivcs-1:0] ivc_ovc_t;

    // destination per input VC
    typedef dest_t [num_ivcs-1:0] ivc_dest_t;

    // destination per input port
    typedef dest_t [num_ports-1:0] port_dest_t;

    // flat index of VC vc at port port_idx
    function automatic int unsigned ivc_index(input int unsigned port_idx,
                                              input int unsigned vc);
        return port_idx * num_vcs + vc;
    endfunction

    // local destination index seen from src_port -> absolute port number
    // indices below the own port keep their value, the rest skip over it
    function automatic int unsigned dest_to_port(input int unsigned src_port,
                                                 input int unsigned dest_idx);
        return (dest_idx < src_port) ? dest_idx : dest_idx + 1;
    endfunction

    // absolute port number -> local index seen from src_port
    // only meaningful when abs_port differs from src_port
    function automatic int unsigned port_to_dest(input int unsigned src_port,
                                                 input int unsigned abs_port);
        return (abs_port < src_port) ? abs_port : abs_port - 1;
    endfunction

endpackage

`default_nettype wire
